// File: list.f
common/uart_rx_mmio_pkg.sv
uart_rx/uart_rx_deser.sv
design/rx_word_ram.sv
design/rx_ring_pointer.sv
design/rx_read_port.sv
design/rx_mmio_ctrl.sv
design/uart_rx_mmio.sv
tb/uart_rx_mmio_props.sv
tb/tb_uart_rx_mmio.sv

// File: tb/tb_uart_rx_mmio.sv
module tb_uart_rx_mmio;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLKS_PER_BIT = 8;
    localparam int CLK_PERIOD   = 100;
    // 6 + 1024 + 1 + 1 + 7 + 12 frames, the single one with a low stop bit included
    localparam int NUM_FRAMES   = 1051;
    localparam longint RUN_LIMIT =
        longint'(NUM_FRAMES) * 10 * CLKS_PER_BIT * CLK_PERIOD * 2 + 1_000_000;

    logic        clk;
    logic        rst_n;
    logic        uart_rx;
    logic        cmd_start;
    logic        cmd_write;
    logic        cmd_ready;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rdata_valid;

    integer      seed;
    logic [7:0]  model_mem [1024];
    bit          model_valid [1024];
    int          model_tail;
    int          model_count;
    bit          frames_done;

    uart_rx_mmio #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx_mmio (
        .clk        (clk),
        .rst_n      (rst_n),
        .uart_rx    (uart_rx),
        .cmd_start  (cmd_start),
        .cmd_write  (cmd_write),
        .cmd_ready  (cmd_ready),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .rdata_valid(rdata_valid)
    );

    bind uart_rx_mmio uart_rx_mmio_props u_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_start  (cmd_start),
        .cmd_write  (cmd_write),
        .cmd_ready  (cmd_ready),
        .ram_wr     (ram_wr),
        .rdata_valid(rdata_valid),
        .state      (u_ctrl.state)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "simulation aborted");
    endtask

    // cmd_ready only changes on clock edges, so the negedge value holds at the next edge
    task automatic wait_accept();
        do @(negedge clk); while (!cmd_ready);
        @(posedge clk);
        #5;
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] data);
        cmd_start = 1'b1;
        cmd_write = 1'b0;
        addr      = a;
        wait_accept();
        cmd_start = 1'b0;
        do @(negedge clk); while (!rdata_valid);
        data = rdata;
        @(posedge clk);
        #5;
    endtask

    task automatic bus_flush();
        cmd_start = 1'b1;
        cmd_write = 1'b1;
        addr      = uart_rx_mmio_pkg::RX_TAIL_OFFSET;
        wdata     = $random(seed);
        wait_accept();
        cmd_start   = 1'b0;
        cmd_write   = 1'b0;
        model_tail  = 0;
        model_count = 0;
    endtask

    // ========================================
    // serial frames and reference model
    // ========================================
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #5;
        end
        uart_rx = 1'b1;
        if (stop_bit) begin
            model_mem[model_tail]   = data;
            model_valid[model_tail] = 1'b1;
            model_tail = (model_tail + 1) % 1024;
            if (model_tail == 0) begin
                model_count++;
            end
        end else begin
            // the line has to rise again before the next start bit is seen
            repeat (2 * CLKS_PER_BIT) @(posedge clk);
            #5;
        end
    endtask

    // lanes never written hold unknown data and are left out of the compare
    task automatic check_word(input logic [7:0] word);
        logic [31:0] got;
        logic [31:0] exp;
        logic [31:0] mask;
        bus_read({22'd0, word, 2'b00}, got);
        for (int l = 0; l < 4; l++) begin
            exp[8*l +: 8]  = model_mem[{word, 2'(l)}];
            mask[8*l +: 8] = model_valid[{word, 2'(l)}] ? 8'hff : 8'h00;
        end
        assert ((got & mask) === (exp & mask)) else
            abort_run($sformatf("mismatch at %0t ns: word %0d read %h, expected %h mask %h",
                                $time, word, got, exp, mask));
    endtask

    task automatic check_reg(input logic [31:0] a, input int exp, input string name);
        logic [31:0] got;
        bus_read(a, got);
        assert (got === 32'(exp)) else
            abort_run($sformatf("mismatch at %0t ns: %s read %0d, expected %0d",
                                $time, name, got, exp));
    endtask

    initial begin
        #(RUN_LIMIT);
        abort_run($sformatf("timeout: the test did not finish within %0d ns", RUN_LIMIT));
    end

    always @(negedge clk) begin
        if (u_uart_rx_mmio.u_props.fail_count != 0) begin
            abort_run("a bound protocol assertion failed");
        end
    end

    // ========================================
    // test sequence
    // ========================================
    initial begin
        seed        = 52;
        clk         = 1'b0;
        rst_n       = 1'b0;
        uart_rx     = 1'b1;
        cmd_start   = 1'b0;
        cmd_write   = 1'b0;
        addr        = '0;
        wdata       = '0;
        model_tail  = 0;
        model_count = 0;
        frames_done = 1'b0;
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(posedge clk);
        #5;
        check_reg(uart_rx_mmio_pkg::RX_TAIL_OFFSET, 0, "tail after reset");
        check_reg(uart_rx_mmio_pkg::RX_COUNT_OFFSET, 0, "count after reset");

        // the first words fill one lane at a time
        for (int i = 0; i < 6; i++) begin
            send_frame(8'($random(seed)), 1'b1);
            check_word(8'd0);
            check_word(8'd1);
            check_reg(uart_rx_mmio_pkg::RX_TAIL_OFFSET, model_tail, "tail");
        end

        for (int i = 0; i < 1024; i++) begin
            send_frame(8'($random(seed)), 1'b1);
        end
        check_reg(uart_rx_mmio_pkg::RX_COUNT_OFFSET, model_count, "count after wrap");
        check_reg(uart_rx_mmio_pkg::RX_TAIL_OFFSET, model_tail, "tail after wrap");
        for (int w = 0; w < 256; w++) begin
            check_word(8'(w));
        end

        bus_flush();
        check_reg(uart_rx_mmio_pkg::RX_TAIL_OFFSET, 0, "tail after flush");
        check_reg(uart_rx_mmio_pkg::RX_COUNT_OFFSET, 0, "count after flush");
        send_frame(8'($random(seed)), 1'b1);
        check_reg(uart_rx_mmio_pkg::RX_TAIL_OFFSET, model_tail, "tail after flush");
        check_word(8'd0);

        // slot 1 still holds old data, so a dropped frame must leave it alone
        send_frame(~model_mem[model_tail], 1'b0);
        check_reg(uart_rx_mmio_pkg::RX_TAIL_OFFSET, model_tail, "tail after bad stop bit");
        check_word(8'd0);

        for (int i = 0; i < 7; i++) begin
            send_frame(8'($random(seed)), 1'b1);
        end
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    send_frame(8'($random(seed)), 1'b1);
                end
                frames_done = 1'b1;
            end
            begin
                while (!frames_done) begin
                    check_word(8'd0);
                    check_word(8'd1);
                end
            end
        join
        for (int w = 0; w < 5; w++) begin
            check_word(8'(w));
        end
        check_reg(uart_rx_mmio_pkg::RX_TAIL_OFFSET, model_tail, "tail after busy reads");
        check_reg(uart_rx_mmio_pkg::RX_COUNT_OFFSET, model_count, "count after busy reads");

        if (u_uart_rx_mmio.u_props.fail_count != 0) begin
            abort_run("a bound protocol assertion failed");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: tb/uart_rx_mmio_props.sv
module uart_rx_mmio_props (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        cmd_start,
    input logic                        cmd_write,
    input logic                        cmd_ready,
    input logic                        ram_wr,
    input logic                        rdata_valid,
    input uart_rx_mmio_pkg::rx_state_e state
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // ========================================
    // bus handshake
    // ========================================

    // valid rises on the second edge after acceptance, and sampling sees it one edge later
    read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_start && cmd_ready && !cmd_write |-> ##2 !rdata_valid ##1 rdata_valid)
    else begin
        $error("read data did not arrive two cycles after an accepted read");
        fail_count++;
    end

    single_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |=> !rdata_valid)
    else begin
        $error("rdata_valid stayed high for two cycles");
        fail_count++;
    end

    // ========================================
    // control states
    // ========================================

    // an accepted read moves the FSM out of IDLE, so the bus is held off next cycle
    read_blocks_bus: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_start && cmd_ready && !cmd_write |=> !cmd_ready)
    else begin
        $error("cmd_ready stayed high in the cycle after an accepted read");
        fail_count++;
    end

    write_after_merge: assert property (@(posedge clk) disable iff (!rst_n)
        ram_wr |-> $past(state) == uart_rx_mmio_pkg::MERGE)
    else begin
        $error("ram_wr was high without a MERGE cycle before it");
        fail_count++;
    end

endmodule

// File: design/uart_rx_mmio.sv
module uart_rx_mmio #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        uart_rx,
    input  logic        cmd_start,
    input  logic        cmd_write,
    output logic        cmd_ready,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        rdata_valid
);

    logic [7:0]                 byte_data;
    logic                       byte_valid;
    logic [31:0]                cmd_addr;
    logic [7:0]                 ram_addr;
    logic                       ram_wr;
    logic [1:0]                 lane;
    logic [7:0]                 lane_byte;
    logic [31:0]                ram_rdata;
    logic                       advance;
    logic                       flush;
    logic                       rd_capture;
    logic [9:0]                 tail;
    logic [31:0]                wrap_count;
    uart_rx_mmio_pkg::reg_sel_e reg_sel;

    uart_rx_deser #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_deser (
        .clk       (clk),
        .rst_n     (rst_n),
        .uart_rx   (uart_rx),
        .byte_data (byte_data),
        .byte_valid(byte_valid)
    );

    // wdata only marks a flush, its value carries nothing
    rx_mmio_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd_write (cmd_write),
        .addr      (addr),
        .byte_valid(byte_valid),
        .byte_data (byte_data),
        .reg_sel   (reg_sel),
        .tail      (tail),
        .cmd_ready (cmd_ready),
        .cmd_addr  (cmd_addr),
        .ram_addr  (ram_addr),
        .ram_wr    (ram_wr),
        .lane      (lane),
        .lane_byte (lane_byte),
        .advance   (advance),
        .flush     (flush),
        .rd_capture(rd_capture)
    );

    rx_word_ram u_ram (
        .clk      (clk),
        .ram_addr (ram_addr),
        .ram_wr   (ram_wr),
        .lane     (lane),
        .lane_byte(lane_byte),
        .ram_rdata(ram_rdata)
    );

    rx_ring_pointer u_ring (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .flush     (flush),
        .tail      (tail),
        .wrap_count(wrap_count)
    );

    rx_read_port u_read (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (cmd_addr),
        .rd_capture (rd_capture),
        .ram_rdata  (ram_rdata),
        .tail       (tail),
        .wrap_count (wrap_count),
        .reg_sel    (reg_sel),
        .rdata      (rdata),
        .rdata_valid(rdata_valid)
    );

endmodule

// File: design/rx_mmio_ctrl.sv
module rx_mmio_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_start,
    input  logic                       cmd_write,
    input  logic [31:0]                addr,
    input  logic                       byte_valid,
    input  logic [7:0]                 byte_data,
    input  uart_rx_mmio_pkg::reg_sel_e reg_sel,
    input  logic [9:0]                 tail,
    output logic                       cmd_ready,
    output logic [31:0]                cmd_addr,
    output logic [7:0]                 ram_addr,
    output logic                       ram_wr,
    output logic [1:0]                 lane,
    output logic [7:0]                 lane_byte,
    output logic                       advance,
    output logic                       flush,
    output logic                       rd_capture
);

    uart_rx_mmio_pkg::rx_state_e state;
    uart_rx_mmio_pkg::rx_state_e state_next;
    logic       accept;
    logic       start_merge;
    logic       pend;
    logic       wr_pend;
    logic [7:0] byte_q;

    // an arriving byte always wins over the bus in the same cycle
    assign cmd_ready = (state == uart_rx_mmio_pkg::IDLE) && !byte_valid && !pend;
    assign accept    = cmd_start && cmd_ready;

    // reg_sel is decoded from cmd_addr, which holds the accepted write address here
    assign flush = wr_pend && (reg_sel == uart_rx_mmio_pkg::SEL_TAIL);

    // ========================================
    // state machine
    // ========================================

    // while a flush clears the tail a new byte waits one cycle
    always_comb begin
        case (state)
            uart_rx_mmio_pkg::IDLE:  start_merge = (byte_valid || pend) && !flush;
            uart_rx_mmio_pkg::READ:  start_merge = byte_valid || pend;
            uart_rx_mmio_pkg::WRITE: start_merge = pend;
            default:                 start_merge = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        if (start_merge) begin
            state_next = uart_rx_mmio_pkg::MERGE;
        end else begin
            case (state)
                uart_rx_mmio_pkg::IDLE: begin
                    if (accept && !cmd_write) begin
                        state_next = uart_rx_mmio_pkg::READ;
                    end
                end
                uart_rx_mmio_pkg::MERGE: state_next = uart_rx_mmio_pkg::WRITE;
                default:                 state_next = uart_rx_mmio_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= uart_rx_mmio_pkg::IDLE;
            pend       <= 1'b0;
            wr_pend    <= 1'b0;
            rd_capture <= 1'b0;
        end else begin
            state <= state_next;
            if (start_merge) begin
                pend <= 1'b0;
            end else if (byte_valid) begin
                pend <= 1'b1;
            end
            wr_pend    <= accept && cmd_write;
            rd_capture <= (state == uart_rx_mmio_pkg::READ);
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            byte_q <= byte_data;
        end
        if (accept) begin
            cmd_addr <= addr;
        end
    end

    // ========================================
    // datapath controls
    // ========================================
    assign ram_addr  = (state == uart_rx_mmio_pkg::READ) ? cmd_addr[9:2] : tail[9:2];
    assign ram_wr    = (state == uart_rx_mmio_pkg::WRITE);
    assign advance   = (state == uart_rx_mmio_pkg::WRITE);
    assign lane      = tail[1:0];
    assign lane_byte = byte_q;

endmodule

// File: design/rx_read_port.sv
module rx_read_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [31:0]                addr,
    input  logic                       rd_capture,
    input  logic [31:0]                ram_rdata,
    input  logic [9:0]                 tail,
    input  logic [31:0]                wrap_count,
    output uart_rx_mmio_pkg::reg_sel_e reg_sel,
    output logic [31:0]                rdata,
    output logic                       rdata_valid
);

    logic [31:0] sel_word;

    // ========================================
    // address decode
    // ========================================
    always_comb begin
        if (addr == uart_rx_mmio_pkg::RX_TAIL_OFFSET) begin
            reg_sel = uart_rx_mmio_pkg::SEL_TAIL;
        end else if (addr == uart_rx_mmio_pkg::RX_COUNT_OFFSET) begin
            reg_sel = uart_rx_mmio_pkg::SEL_COUNT;
        end else begin
            reg_sel = uart_rx_mmio_pkg::SEL_BUF;
        end
    end

    always_comb begin
        case (reg_sel)
            uart_rx_mmio_pkg::SEL_TAIL:  sel_word = {22'd0, tail};
            uart_rx_mmio_pkg::SEL_COUNT: sel_word = wrap_count;
            default:                     sel_word = ram_rdata;
        endcase
    end

    // ========================================
    // read data register
    // ========================================
    always_ff @(posedge clk) begin
        if (rd_capture) begin
            rdata <= sel_word;
        end
    end

    // one valid cycle per captured read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd_capture;
        end
    end

endmodule

// File: design/rx_ring_pointer.sv
module rx_ring_pointer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        advance,
    input  logic        flush,
    output logic [9:0]  tail,
    output logic [31:0] wrap_count
);

    logic at_last;

    assign at_last = (tail == 10'd1023);

    // tail is the byte index of the next free slot and wraps at 1024
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail       <= 10'd0;
            wrap_count <= 32'd0;
        end else if (flush) begin
            tail       <= 10'd0;
            wrap_count <= 32'd0;
        end else if (advance) begin
            tail <= tail + 10'd1;
            if (at_last) begin
                wrap_count <= wrap_count + 32'd1;
            end
        end
    end

endmodule

// File: design/rx_word_ram.sv
module rx_word_ram (
    input  logic        clk,
    input  logic [7:0]  ram_addr,
    input  logic        ram_wr,
    input  logic [1:0]  lane,
    input  logic [7:0]  lane_byte,
    output logic [31:0] ram_rdata
);

    logic [31:0] mem [uart_rx_mmio_pkg::RX_BUF_WORDS];
    logic [31:0] merged;

    // the word read in the cycle before a write is the one being updated
    always_comb begin
        merged = ram_rdata;
        case (lane)
            2'd0: merged[7:0]   = lane_byte;
            2'd1: merged[15:8]  = lane_byte;
            2'd2: merged[23:16] = lane_byte;
            default: merged[31:24] = lane_byte;
        endcase
    end

    // ========================================
    // storage
    // ========================================

    // read every cycle, a write returns the old word on the same edge
    always_ff @(posedge clk) begin
        if (ram_wr) begin
            mem[ram_addr] <= merged;
        end
        ram_rdata <= mem[ram_addr];
    end

endmodule

// File: uart_rx/uart_rx_deser.sv
module uart_rx_deser #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic [7:0] byte_data,
    output logic       byte_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } deser_state_e;

    deser_state_e     state;
    logic [1:0]       rx_sync;
    logic             rx_prev;
    logic             rx_fall;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    // two flops against metastability, the line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
            rx_prev <= rx_sync[1];
        end
    end

    assign rx_fall = rx_prev && !rx_sync[1];

    // ========================================
    // frame FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= 3'd0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_fall) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    // a glitch shorter than half a bit is not a start bit
                    if (clk_cnt == HALF_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= 3'd0;
                        state   <= rx_sync[1] ? S_IDLE : S_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (clk_cnt == FULL_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    // frames with a low stop bit are dropped here
                    if (clk_cnt == FULL_CNT) begin
                        clk_cnt    <= '0;
                        byte_valid <= rx_sync[1];
                        state      <= S_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // data arrives lsb first so it shifts in from the top
    always_ff @(posedge clk) begin
        if (state == S_DATA && clk_cnt == FULL_CNT) begin
            shift_q <= {rx_sync[1], shift_q[7:1]};
        end
    end

    assign byte_data = shift_q;

endmodule

// File: common/uart_rx_mmio_pkg.sv
package uart_rx_mmio_pkg;

    // ========================================
    // address map
    // ========================================

    // byte offsets seen by the bus master
    // anything that is not one of the two registers reads the buffer at addr[9:2]
    localparam logic [31:0] RX_TAIL_OFFSET  = 32'h0000_0400;
    localparam logic [31:0] RX_COUNT_OFFSET = 32'h0000_0404;

    // 256 words of 4 bytes fill exactly the 1 KiB below the tail register
    localparam int RX_BUF_WORDS = 256;

    // ========================================
    // control and decode types
    // ========================================

    // MERGE reads the tail word, WRITE stores it back with the new byte in place
    typedef enum logic [1:0] {
        IDLE,
        MERGE,
        WRITE,
        READ
    } rx_state_e;

    // source of the read data for a bus read
    typedef enum logic [1:0] {
        SEL_BUF,
        SEL_TAIL,
        SEL_COUNT
    } reg_sel_e;

endpackage
